// File: Makefile
TB_TOP = coreTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --timescale 1ns/1ps -j 0 -f compile.f \
		--top-module $(TB_TOP) -o $(TB_TOP)

run: build
	@out=$$(./obj_dir/$(TB_TOP)); echo "$$out"; echo "$$out" | grep -qx "Test passed"

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f compile.f \
		--top-module $(TB_TOP)
	verilator --lint-only --assert -Ihdl hdl/corePkg.sv hdl/controlDecoder.sv \
		hdl/regFile.sv hdl/alu.sv hdl/hazardUnit.sv hdl/decodeStage.sv \
		hdl/executeStage.sv hdl/pipelineCore.sv --top-module pipelineCore

clean:
	rm -rf obj_dir

// File: compile.f
+incdir+hdl
hdl/corePkg.sv
hdl/controlDecoder.sv
hdl/regFile.sv
hdl/alu.sv
hdl/hazardUnit.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/pipelineCore.sv
tests/coreTb.sv

// File: hdl/alu.sv
`include "core_config.svh"

module alu (
    input  logic [`DATA_WIDTH-1:0] a,
    input  logic [`DATA_WIDTH-1:0] b,
    input  corePkg::aluOp_t        op,
    output logic [`DATA_WIDTH-1:0] y
);

    logic                   subtract;
    logic [`DATA_WIDTH-1:0] sum;
    logic                   lessThan;

    // sub and slt reuse the adder with ~b + 1
    assign subtract = (op == corePkg::aluSub) || (op == corePkg::aluSlt);
    assign sum = a + (subtract ? ~b : b) + `DATA_WIDTH'(subtract);

    // signs differ means no overflow question, a's sign decides
    assign lessThan = (a[`DATA_WIDTH-1] != b[`DATA_WIDTH-1]) ? a[`DATA_WIDTH-1]
                                                             : sum[`DATA_WIDTH-1];

    always_comb begin
        case (op)
            corePkg::aluAnd:  y = a & b;
            corePkg::aluOr:   y = a | b;
            corePkg::aluXor:  y = a ^ b;
            corePkg::aluXnor: y = ~(a ^ b);
            corePkg::aluSlt:  y = `DATA_WIDTH'(lessThan);
            corePkg::aluLui:  y = b << `LUI_SHIFT;
            default:          y = sum;  // add, sub
        endcase
    end

endmodule

// File: hdl/controlDecoder.sv
module controlDecoder (
    input  logic            clk,
    input  logic            rst,
    input  corePkg::instr_t instr,
    output corePkg::ctrl_t  ctrl,
    output logic            illegal
);

    always_comb begin
        ctrl = '0;
        ctrl.aluOp = corePkg::aluAdd;  // address and branch default
        illegal = 1'b0;
        case (instr.iFmt.opcode)
            6'h00: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst = 1'b1;
                case (instr.rFmt.funct)
                    6'h00: ctrl.regWrite = 1'b0;  // nop
                    6'h20: ctrl.aluOp = corePkg::aluAdd;
                    6'h22: ctrl.aluOp = corePkg::aluSub;
                    6'h24: ctrl.aluOp = corePkg::aluAnd;
                    6'h25: ctrl.aluOp = corePkg::aluOr;
                    6'h26: ctrl.aluOp = corePkg::aluXor;
                    6'h27: ctrl.aluOp = corePkg::aluXnor;
                    6'h2a: ctrl.aluOp = corePkg::aluSlt;
                    default: illegal = 1'b1;
                endcase
            end
            6'h08, 6'h0a, 6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                // logical immediates sit at 0x0c..0x0e, lui drops the upper half anyway
                ctrl.zeroExt = instr.iFmt.opcode[2];
                case (instr.iFmt.opcode[2:0])
                    3'b000: ctrl.aluOp = corePkg::aluAdd;  // addi
                    3'b010: ctrl.aluOp = corePkg::aluSlt;  // slti
                    3'b100: ctrl.aluOp = corePkg::aluAnd;
                    3'b101: ctrl.aluOp = corePkg::aluOr;
                    3'b110: ctrl.aluOp = corePkg::aluXor;
                    default: ctrl.aluOp = corePkg::aluLui;
                endcase
            end
            6'h23: begin  // lw
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            6'h2b: begin  // sw
                ctrl.memWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            6'h04: ctrl.branchEq = 1'b1;
            6'h05: ctrl.branchNe = 1'b1;
            6'h03: begin  // jal
                ctrl.jump = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
        if (illegal) begin
            ctrl = '0;  // unknown encodings retire as a bubble
        end
    end

    // every word that reaches decode must belong to the supported set
    assert property (@(posedge clk) disable iff (rst) (instr != '0) |-> !illegal);

endmodule

// File: hdl/corePkg.sv
`include "core_config.svh"

package corePkg;

    // register format
    typedef struct packed {
        logic [5:0]                 opcode;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [4:0]                 shamt;
        logic [5:0]                 funct;
    } rFmt_t;

    // immediate format
    typedef struct packed {
        logic [5:0]                 opcode;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [15:0]                imm16;
    } iFmt_t;

    // jump format
    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target26;
    } jFmt_t;

    // one instruction word, three views
    typedef union packed {
        rFmt_t rFmt;
        iFmt_t iFmt;
        jFmt_t jFmt;
    } instr_t;

    typedef enum logic [2:0] {
        aluAnd  = 3'b000,
        aluOr   = 3'b001,
        aluAdd  = 3'b010,
        aluXor  = 3'b011,
        aluXnor = 3'b100,
        aluSub  = 3'b101,
        aluSlt  = 3'b110,
        aluLui  = 3'b111
    } aluOp_t;

    typedef struct packed {
        logic   regWrite;
        logic   memWrite;
        logic   memToReg;
        logic   aluSrcImm;
        logic   zeroExt;   // andi/ori/xori
        logic   regDst;    // rd instead of rt
        logic   branchEq;
        logic   branchNe;
        logic   jump;
        aluOp_t aluOp;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                      ctrl;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`DATA_WIDTH-1:0]     rd1;
        logic [`DATA_WIDTH-1:0]     rd2;
        logic [`DATA_WIDTH-1:0]     imm;
        logic [`DATA_WIDTH-1:0]     pcPlus4;
    } idEx_t;

    typedef struct packed {
        logic                       regWrite;
        logic                       memWrite;
        logic                       memToReg;
        logic                       link;      // jal, result is pcPlus8
        logic [`REG_ADDR_WIDTH-1:0] writeReg;
        logic [`DATA_WIDTH-1:0]     aluOut;
        logic [`DATA_WIDTH-1:0]     writeData;
        logic [`DATA_WIDTH-1:0]     pcPlus8;
    } exMem_t;

    typedef enum logic [1:0] {
        fwdNone    = 2'b00,
        fwdFromMem = 2'b10,
        fwdFromWb  = 2'b01
    } fwdSel_t;

endpackage

// File: hdl/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// machine word and register index widths
`define DATA_WIDTH 32
`define REG_ADDR_WIDTH 5

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

// jal destination register
`define LINK_REG 31

// lui places the immediate in the upper half
`define LUI_SHIFT 16

`endif

// File: hdl/decodeStage.sv
`include "core_config.svh"

module decodeStage (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       stall,
    input  corePkg::instr_t            instrF,
    input  logic [`DATA_WIDTH-1:0]     pcPlus4F,
    input  logic                       forwardAD,
    input  logic                       forwardBD,
    input  logic [`DATA_WIDTH-1:0]     aluOutM,
    input  logic [`REG_ADDR_WIDTH-1:0] writeRegW,
    input  logic [`DATA_WIDTH-1:0]     resultW,
    input  logic                       regWriteW,
    output corePkg::idEx_t             idEx,
    output logic [`REG_ADDR_WIDTH-1:0] rsD,
    output logic [`REG_ADDR_WIDTH-1:0] rtD,
    output logic                       branchD,
    output logic [`DATA_WIDTH-1:0]     pcNext
);

    corePkg::instr_t        instrD;
    corePkg::ctrl_t         ctrlD;
    logic [`DATA_WIDTH-1:0] pcPlus4D;
    logic [`DATA_WIDTH-1:0] rdA;
    logic [`DATA_WIDTH-1:0] rdB;
    logic [`DATA_WIDTH-1:0] srcA;
    logic [`DATA_WIDTH-1:0] srcB;
    logic [`DATA_WIDTH-1:0] immD;
    logic [`DATA_WIDTH-1:0] branchTarget;
    logic [`DATA_WIDTH-1:0] jumpTarget;
    logic                   takenD;
    logic                   redirect;

    // fetch/decode register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            instrD <= '0;
            pcPlus4D <= '0;
        end else if (!stall) begin
            if (redirect) begin
                instrD <= '0;  // squash the word fetched behind
                pcPlus4D <= '0;
            end else begin
                instrD <= instrF;
                pcPlus4D <= pcPlus4F;
            end
        end
    end

    controlDecoder ctrlDec (
        .clk(clk),
        .rst(rst),
        .instr(instrD),
        .ctrl(ctrlD),
        .illegal()
    );

    regFile regs (
        .clk(clk),
        .rst(rst),
        .raddrA(instrD.rFmt.rs),
        .raddrB(instrD.rFmt.rt),
        .waddr(writeRegW),
        .wdata(resultW),
        .wen(regWriteW),
        .rdataA(rdA),
        .rdataB(rdB)
    );

    assign rsD = instrD.rFmt.rs;
    assign rtD = instrD.rFmt.rt;

    assign immD = ctrlD.zeroExt ? {{(`DATA_WIDTH-16){1'b0}}, instrD.iFmt.imm16}
                                : {{(`DATA_WIDTH-16){instrD.iFmt.imm16[15]}}, instrD.iFmt.imm16};

    // early branch resolution
    assign srcA = forwardAD ? aluOutM : rdA;
    assign srcB = forwardBD ? aluOutM : rdB;
    assign takenD = (ctrlD.branchEq && srcA == srcB) || (ctrlD.branchNe && srcA != srcB);
    assign branchD = ctrlD.branchEq || ctrlD.branchNe;
    assign redirect = takenD || ctrlD.jump;

    assign branchTarget = pcPlus4D + (immD << 2);
    assign jumpTarget = {pcPlus4D[`DATA_WIDTH-1:28], instrD.jFmt.target26, 2'b00};
    assign pcNext = ctrlD.jump ? jumpTarget : takenD ? branchTarget : pcPlus4F;

    always_comb begin
        idEx.ctrl = ctrlD;
        idEx.rs = instrD.rFmt.rs;
        idEx.rt = instrD.rFmt.rt;
        idEx.rd = instrD.rFmt.rd;
        idEx.rd1 = rdA;
        idEx.rd2 = rdB;
        idEx.imm = immD;
        idEx.pcPlus4 = pcPlus4D;
    end

endmodule

// File: hdl/executeStage.sv
`include "core_config.svh"

module executeStage (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush,
    input  corePkg::idEx_t             idEx,
    input  corePkg::fwdSel_t           forwardA,
    input  corePkg::fwdSel_t           forwardB,
    input  logic [`DATA_WIDTH-1:0]     aluOutM,
    input  logic [`DATA_WIDTH-1:0]     resultW,
    output logic [`REG_ADDR_WIDTH-1:0] rsE,
    output logic [`REG_ADDR_WIDTH-1:0] rtE,
    output logic [`REG_ADDR_WIDTH-1:0] writeRegE,
    output logic                       regWriteE,
    output logic                       memToRegE,
    output corePkg::exMem_t            exMem
);

    corePkg::idEx_t         idExE;
    logic [`DATA_WIDTH-1:0] srcA;
    logic [`DATA_WIDTH-1:0] srcB;
    logic [`DATA_WIDTH-1:0] writeDataE;
    logic [`DATA_WIDTH-1:0] aluY;

    // decode/execute register, flush inserts a bubble
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idExE <= '0;
        end else if (flush) begin
            idExE <= '0;
        end else begin
            idExE <= idEx;
        end
    end

    always_comb begin
        case (forwardA)
            corePkg::fwdFromMem: srcA = aluOutM;
            corePkg::fwdFromWb:  srcA = resultW;
            default:             srcA = idExE.rd1;
        endcase
        case (forwardB)
            corePkg::fwdFromMem: writeDataE = aluOutM;
            corePkg::fwdFromWb:  writeDataE = resultW;
            default:             writeDataE = idExE.rd2;
        endcase
    end

    assign srcB = idExE.ctrl.aluSrcImm ? idExE.imm : writeDataE;

    alu aluInst (
        .a(srcA),
        .b(srcB),
        .op(idExE.ctrl.aluOp),
        .y(aluY)
    );

    assign rsE = idExE.rs;
    assign rtE = idExE.rt;
    assign regWriteE = idExE.ctrl.regWrite;
    assign memToRegE = idExE.ctrl.memToReg;
    assign writeRegE = idExE.ctrl.jump ? `REG_ADDR_WIDTH'(`LINK_REG)
                     : idExE.ctrl.regDst ? idExE.rd : idExE.rt;

    // execute/memory register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exMem <= '0;
        end else begin
            exMem.regWrite <= idExE.ctrl.regWrite;
            exMem.memWrite <= idExE.ctrl.memWrite;
            exMem.memToReg <= idExE.ctrl.memToReg;
            exMem.link <= idExE.ctrl.jump;
            exMem.writeReg <= writeRegE;
            exMem.aluOut <= aluY;
            exMem.writeData <= writeDataE;
            exMem.pcPlus8 <= idExE.pcPlus4 + `DATA_WIDTH'(4);
        end
    end

    // store strobe reaches the data bus every cycle after reset
    assert property (@(posedge clk) disable iff (rst) !$isunknown(exMem.memWrite));

endmodule

// File: hdl/hazardUnit.sv
`include "core_config.svh"

module hazardUnit (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`REG_ADDR_WIDTH-1:0] rsD,
    input  logic [`REG_ADDR_WIDTH-1:0] rtD,
    input  logic [`REG_ADDR_WIDTH-1:0] rsE,
    input  logic [`REG_ADDR_WIDTH-1:0] rtE,
    input  logic [`REG_ADDR_WIDTH-1:0] writeRegE,
    input  logic [`REG_ADDR_WIDTH-1:0] writeRegM,
    input  logic [`REG_ADDR_WIDTH-1:0] writeRegW,
    input  logic                       regWriteE,
    input  logic                       regWriteM,
    input  logic                       regWriteW,
    input  logic                       memToRegE,
    input  logic                       memToRegM,
    input  logic                       branchD,
    output logic                       stall,
    output logic                       flush,
    output logic                       forwardAD,
    output logic                       forwardBD,
    output corePkg::fwdSel_t           forwardA,
    output corePkg::fwdSel_t           forwardB
);

    logic loadUse;
    logic branchHazard;

    // memory stage wins over writeback, r0 never forwarded
    always_comb begin
        forwardA = corePkg::fwdNone;
        if (rsE != '0 && regWriteM && rsE == writeRegM) begin
            forwardA = corePkg::fwdFromMem;
        end else if (rsE != '0 && regWriteW && rsE == writeRegW) begin
            forwardA = corePkg::fwdFromWb;
        end
        forwardB = corePkg::fwdNone;
        if (rtE != '0 && regWriteM && rtE == writeRegM) begin
            forwardB = corePkg::fwdFromMem;
        end else if (rtE != '0 && regWriteW && rtE == writeRegW) begin
            forwardB = corePkg::fwdFromWb;
        end
    end

    // branch compare only sees the memory stage, writeback comes via the regfile
    assign forwardAD = (rsD != '0) && regWriteM && (rsD == writeRegM);
    assign forwardBD = (rtD != '0) && regWriteM && (rtD == writeRegM);

    assign loadUse = memToRegE && (writeRegE == rsD || writeRegE == rtD);
    assign branchHazard = branchD &&
        ((regWriteE && (writeRegE == rsD || writeRegE == rtD)) ||
         (memToRegM && (writeRegM == rsD || writeRegM == rtD)));

    assign stall = loadUse || branchHazard;
    assign flush = stall;  // bubble into execute while decode holds

    // a load feeding a branch is the longest case, two cycles
    assert property (@(posedge clk) disable iff (rst) stall ##1 stall |=> !stall);

endmodule

// File: hdl/pipelineCore.sv
`include "core_config.svh"

module pipelineCore (
    input  logic                   clk,
    input  logic                   rst,
    output logic [`DATA_WIDTH-1:0] pc,
    input  corePkg::instr_t        instr,
    output logic [`DATA_WIDTH-1:0] dataAddr,
    output logic [`DATA_WIDTH-1:0] writeData,
    output logic                   memWrite,
    input  logic [`DATA_WIDTH-1:0] readData
);

    logic [`DATA_WIDTH-1:0]     pcPlus4F;
    logic [`DATA_WIDTH-1:0]     pcNext;
    logic                       stall;
    logic                       flush;
    logic                       forwardAD;
    logic                       forwardBD;
    corePkg::fwdSel_t           forwardA;
    corePkg::fwdSel_t           forwardB;
    corePkg::idEx_t             idEx;
    corePkg::exMem_t            exMem;
    corePkg::exMem_t            memWb;
    logic [`DATA_WIDTH-1:0]     readDataW;
    logic [`DATA_WIDTH-1:0]     aluOutM;
    logic [`DATA_WIDTH-1:0]     resultW;
    logic [`REG_ADDR_WIDTH-1:0] rsD;
    logic [`REG_ADDR_WIDTH-1:0] rtD;
    logic [`REG_ADDR_WIDTH-1:0] rsE;
    logic [`REG_ADDR_WIDTH-1:0] rtE;
    logic [`REG_ADDR_WIDTH-1:0] writeRegE;
    logic                       branchD;
    logic                       regWriteE;
    logic                       memToRegE;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else if (!stall) begin
            pc <= pcNext;
        end
    end

    assign pcPlus4F = pc + `DATA_WIDTH'(4);

    decodeStage decode (
        .clk(clk), .rst(rst), .stall(stall),
        .instrF(instr), .pcPlus4F(pcPlus4F),
        .forwardAD(forwardAD), .forwardBD(forwardBD), .aluOutM(aluOutM),
        .writeRegW(memWb.writeReg), .resultW(resultW), .regWriteW(memWb.regWrite),
        .idEx(idEx), .rsD(rsD), .rtD(rtD), .branchD(branchD), .pcNext(pcNext)
    );

    executeStage execute (
        .clk(clk), .rst(rst), .flush(flush), .idEx(idEx),
        .forwardA(forwardA), .forwardB(forwardB),
        .aluOutM(aluOutM), .resultW(resultW),
        .rsE(rsE), .rtE(rtE), .writeRegE(writeRegE),
        .regWriteE(regWriteE), .memToRegE(memToRegE), .exMem(exMem)
    );

    hazardUnit hazard (
        .clk(clk), .rst(rst),
        .rsD(rsD), .rtD(rtD), .rsE(rsE), .rtE(rtE),
        .writeRegE(writeRegE), .writeRegM(exMem.writeReg), .writeRegW(memWb.writeReg),
        .regWriteE(regWriteE), .regWriteM(exMem.regWrite), .regWriteW(memWb.regWrite),
        .memToRegE(memToRegE), .memToRegM(exMem.memToReg), .branchD(branchD),
        .stall(stall), .flush(flush), .forwardAD(forwardAD), .forwardBD(forwardBD),
        .forwardA(forwardA), .forwardB(forwardB)
    );

    // data bus straight from the memory stage
    assign dataAddr = exMem.aluOut;
    assign writeData = exMem.writeData;
    assign memWrite = exMem.memWrite;

    // a jal in memory forwards its link value
    assign aluOutM = exMem.link ? exMem.pcPlus8 : exMem.aluOut;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            memWb <= '0;
        end else begin
            memWb <= exMem;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            readDataW <= '0;
        end else begin
            readDataW <= readData;
        end
    end

    assign resultW = memWb.link ? memWb.pcPlus8 : memWb.memToReg ? readDataW : memWb.aluOut;

endmodule

// File: hdl/regFile.sv
`include "core_config.svh"

module regFile (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`REG_ADDR_WIDTH-1:0] raddrA,
    input  logic [`REG_ADDR_WIDTH-1:0] raddrB,
    input  logic [`REG_ADDR_WIDTH-1:0] waddr,
    input  logic [`DATA_WIDTH-1:0]     wdata,
    input  logic                       wen,
    output logic [`DATA_WIDTH-1:0]     rdataA,
    output logic [`DATA_WIDTH-1:0]     rdataB
);

    logic [`DATA_WIDTH-1:0] regs [2**`REG_ADDR_WIDTH];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 2**`REG_ADDR_WIDTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 reads zero, same-cycle write passes straight through
    assign rdataA = (raddrA == '0) ? '0 : (wen && waddr == raddrA) ? wdata : regs[raddrA];
    assign rdataB = (raddrB == '0) ? '0 : (wen && waddr == raddrB) ? wdata : regs[raddrB];

endmodule

// File: tests/coreTb.sv
`include "core_config.svh"

module coreTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_WORDS = 256;
    localparam int STORE_TIMEOUT = 200;
    localparam int QUIET_CYCLES = 40;

    logic                   clk;
    logic                   rst;
    logic [`DATA_WIDTH-1:0] pc;
    corePkg::instr_t        instr;
    logic [`DATA_WIDTH-1:0] dataAddr;
    logic [`DATA_WIDTH-1:0] writeData;
    logic                   memWrite;
    logic [`DATA_WIDTH-1:0] readData;

    logic [`DATA_WIDTH-1:0] progMem [MEM_WORDS];
    logic [`DATA_WIDTH-1:0] dataMem [MEM_WORDS];

    string       testNames[$];
    int          testCounts[$];
    logic [31:0] expAddr[$];
    logic [31:0] expData[$];

    int errors;
    int failedTests;
    int testsRun;
    bit aborted;

    pipelineCore dut_i (
        .clk(clk),
        .rst(rst),
        .pc(pc),
        .instr(instr),
        .dataAddr(dataAddr),
        .writeData(writeData),
        .memWrite(memWrite),
        .readData(readData)
    );

    always #10 clk = ~clk;

    // both memories are word indexed and answer in the same cycle
    assign instr = progMem[pc[9:2]];
    assign readData = dataMem[dataAddr[9:2]];

    always @(posedge clk) begin
        if (!rst && memWrite) begin
            dataMem[dataAddr[9:2]] <= writeData;
        end
    end

    task automatic loadVectors(output bit ok);
        int          fd;
        int          n;
        int          count;
        string       line;
        string       name;
        byte         tag;
        logic [31:0] addr;
        logic [31:0] words [4];
        ok = 1'b0;
        fd = $fopen("tests/core_vectors.txt", "r");
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2) begin
                continue;
            end
            tag = line.getc(0);
            case (tag)
                "P": begin
                    n = $sscanf(line, "P %h %h %h %h %h", addr,
                                words[0], words[1], words[2], words[3]);
                    for (int i = 0; i < n - 1; i++) begin
                        progMem[int'(addr[9:2]) + i] = words[i];
                    end
                end
                "D": begin
                    n = $sscanf(line, "D %h %h", addr, words[0]);
                    dataMem[addr[9:2]] = words[0];
                end
                "T": begin
                    n = $sscanf(line, "T %s %d", name, count);
                    testNames.push_back(name);
                    testCounts.push_back(count);
                end
                "S": begin
                    n = $sscanf(line, "S %h %h", addr, words[0]);
                    expAddr.push_back(addr);
                    expData.push_back(words[0]);
                end
                default: ;  // comment line
            endcase
        end
        $fclose(fd);
        ok = testNames.size() > 0;
    endtask

    // returns at the first negedge that shows a store strobe
    task automatic waitStore(output bit seen);
        int cycles;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < STORE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            seen = memWrite;
        end
    endtask

    task automatic checkReset();
        int resetErrors;
        resetErrors = 0;
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            if (memWrite !== 1'b0) begin
                $display("Error: memWrite expected 0x0 got 0x%h during reset", memWrite);
                resetErrors++;
            end
            if (pc !== `RESET_PC) begin
                $display("Error: pc expected 0x%08h got 0x%08h during reset", `RESET_PC, pc);
                resetErrors++;
            end
            @(posedge clk);
        end
        rst <= 1'b0;
        @(negedge clk);
        if (pc !== `RESET_PC) begin
            $display("Error: pc expected 0x%08h got 0x%08h at first fetch", `RESET_PC, pc);
            resetErrors++;
        end
        if (memWrite !== 1'b0) begin
            $display("Error: memWrite expected 0x0 got 0x%h after reset", memWrite);
            resetErrors++;
        end
        testsRun++;
        errors += resetErrors;
        if (resetErrors != 0) begin
            failedTests++;
        end
        $display("reset: %0d errors", resetErrors);
    endtask

    task automatic runStoreTest(input int t, inout int storeIdx);
        int testErrors;
        bit seen;
        testErrors = 0;
        for (int k = 0; k < testCounts[t] && !aborted; k++) begin
            waitStore(seen);
            if (!seen) begin
                $display("test %s: store %0d to address 0x%08h never arrived",
                         testNames[t], k, expAddr[storeIdx]);
                testErrors++;
                aborted = 1'b1;
            end else begin
                if (dataAddr !== expAddr[storeIdx]) begin
                    $display("Error: dataAddr expected 0x%08h got 0x%08h (test %s store %0d)",
                             expAddr[storeIdx], dataAddr, testNames[t], k);
                    testErrors++;
                end
                if (writeData !== expData[storeIdx]) begin
                    $display("Error: writeData expected 0x%08h got 0x%08h (test %s store %0d)",
                             expData[storeIdx], writeData, testNames[t], k);
                    testErrors++;
                end
            end
            storeIdx++;
        end
        testsRun++;
        errors += testErrors;
        if (testErrors != 0) begin
            failedTests++;
        end
        $display("%s: %0d stores, %0d errors", testNames[t], testCounts[t], testErrors);
    endtask

    // squashed and skipped stores must never show up once the program parks
    task automatic checkQuiet();
        int extra;
        extra = 0;
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge clk);
            if (memWrite) begin
                $display("unexpected store to address 0x%08h with data 0x%08h",
                         dataAddr, writeData);
                extra++;
            end
        end
        testsRun++;
        errors += extra;
        if (extra != 0) begin
            failedTests++;
        end
        $display("noExtraStores: %0d errors", extra);
    endtask

    initial begin
        bit loaded;
        int storeIdx;
        clk = 1'b0;
        rst = 1'b1;
        errors = 0;
        failedTests = 0;
        testsRun = 0;
        aborted = 1'b0;
        storeIdx = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            progMem[i] = '0;  // nop
            dataMem[i] = {24'hDA7A00, i[7:0]};
        end
        loadVectors(loaded);
        if (!loaded) begin
            $display("could not read any test from tests/core_vectors.txt");
            aborted = 1'b1;
        end
        checkReset();
        for (int t = 0; t < testNames.size() && !aborted; t++) begin
            runStoreTest(t, storeIdx);
        end
        if (!aborted) begin
            checkQuiet();
        end
        $display("%0d tests run, %0d failed, %0d errors", testsRun, failedTests, errors);
        if (errors == 0 && !aborted) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tests/core_vectors.txt
# P addr word0 word1 word2 word3 : program words from byte address addr, all hex
# D addr word : initial data word, T name count : test owning the next count stores
# S addr data : expected store in program order, hex
D 00000080 11223344
P 00000000 20011234 2002FFFD 00221820 00222022
P 00000010 00222824 00223025 00223826 00224027
P 00000020 0041482A 282AFFFF 304BF0F0 340C8001
P 00000030 384D8000 3C0EBEEF AC030000 AC040004
P 00000040 AC050008 AC06000C AC070010 AC080014
P 00000050 AC090018 AC0A001C AC0B0020 AC0C0024
P 00000060 AC0D0028 AC0E002C 8C0F0080 21F00001
P 00000070 02108820 02309022 AC120030 AC0F0034
P 00000080 AC110038 20140005 12800002 AC140040
P 00000090 16800001 AC140044 12940001 AC000048
P 000000A0 16940001 22950002 AC15004C 0C00002E
P 000000B0 AC000050 AC000054 AC1F0050 20000055
P 000000C0 0000B020 AC000058 AC16005C 1000FFFF
T alu 12
S 00000000 00001231
S 00000004 00001237
S 00000008 00001234
S 0000000C FFFFFFFD
S 00000010 FFFFEDC9
S 00000014 00001236
S 00000018 00000001
S 0000001C 00000000
S 00000020 0000F0F0
S 00000024 00008001
S 00000028 FFFF7FFD
S 0000002C BEEF0000
T forward 3
S 00000030 11223345
S 00000034 11223344
S 00000038 2244668A
T branch 2
S 00000040 00000005
S 0000004C 00000007
T jal 1
S 00000050 000000B4
T zeroReg 2
S 00000058 00000000
S 0000005C 00000000
